// ==== Makefile ====
# Verilator flow for the data MMU

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= tb_mmu
RTL_TOP    ?= mmu_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== design/mmu_top.sv ====
/*
 * data-side address translation unit
 * TLB, page table walker and permission checker joined together
 */
`timescale 1ns/10ps

module mmu_top
    import tlb_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  mem_req_t              req,
    input  satp_t                 satp,
    input  prv_t                  prv,
    input  logic                  fence,
    input  fence_t                fence_cfg,
    input  logic [31:0]           pt_rdata,
    input  logic                  pt_busy,
    output logic                  busy,
    output logic [PADDR_BITS-1:0] paddr,
    output logic                  fault_load,
    output logic                  fault_store,
    output logic                  fence_done,
    output logic                  pt_ren,
    output logic [PADDR_BITS-1:0] pt_addr
);

    pte_t      hit_pte;
    logic      hit;
    access_t   access;
    logic      walk_start;
    va_u       walk_va;
    walk_rsp_t walk_rsp;
    logic      walk_fault;
    logic      chk_fault_load;
    logic      chk_fault_store;

    tlb tlb0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (req),
        .satp       (satp),
        .fence      (fence),
        .fence_cfg  (fence_cfg),
        .walk_rsp   (walk_rsp),
        .busy       (busy),
        .paddr      (paddr),
        .hit_pte    (hit_pte),
        .hit        (hit),
        .access     (access),
        .walk_start (walk_start),
        .walk_va    (walk_va),
        .walk_fault (walk_fault),
        .fence_done (fence_done)
    );

    page_walker walker0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .start    (walk_start),
        .va       (walk_va),
        .root_ppn (satp.ppn),
        .pt_rdata (pt_rdata),
        .pt_busy  (pt_busy),
        .pt_ren   (pt_ren),
        .pt_addr  (pt_addr),
        .rsp      (walk_rsp)
    );

    page_perm_check perm0 (
        .check       (hit),
        .access      (access),
        .pte         (hit_pte),
        .prv         (prv),
        .fault_load  (chk_fault_load),
        .fault_store (chk_fault_store)
    );

    // walk faults take the type of the pending access
    assign fault_load  = chk_fault_load || (walk_fault && access == ACCESS_LOAD);
    assign fault_store = chk_fault_store || (walk_fault && access == ACCESS_STORE);

    // a fault only comes out together with the pipeline release
    a_fault_release: assert property (@(posedge CLK) disable iff (!nRST)
        fault_load || fault_store |-> !busy);

endmodule

// ==== design/page_perm_check.sv ====
/*
 * Sv32 leaf permission check
 * raises a load or store page fault for the access against the leaf pte
 */
`timescale 1ns/10ps

module page_perm_check
    import tlb_pkg::*;
(
    input  logic    check,
    input  access_t access,
    input  pte_t    pte,
    input  prv_t    prv,
    output logic    fault_load,
    output logic    fault_store
);

    logic priv_bad;  // invalid leaf or wrong privilege
    logic load_ok;
    logic store_ok;

    always_comb begin
        priv_bad = !pte.perms.v;
        // supervisor touching a user page
        if (prv.mode == PRV_S && pte.perms.u && !prv.sum) begin
            priv_bad = 1'b1;
        end
        if (prv.mode == PRV_U && !pte.perms.u) begin
            priv_bad = 1'b1;
        end
    end

    // a and d are not maintained here, so they are not checked
    assign load_ok  = pte.perms.r || (pte.perms.x && prv.mxr);  // mxr makes x readable
    assign store_ok = pte.perms.r && pte.perms.w;

    assign fault_load  = check && access == ACCESS_LOAD && (priv_bad || !load_ok);
    assign fault_store = check && access == ACCESS_STORE && (priv_bad || !store_ok);

endmodule

// ==== design/page_walker.sv ====
/*
 * two-level Sv32 page table walker
 * reads through a plain memory port, returns the leaf pte or a fault
 */
`timescale 1ns/10ps

module page_walker
    import tlb_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  start,
    input  va_u                   va,
    input  logic [PPN_BITS-1:0]   root_ppn,
    input  logic [31:0]           pt_rdata,
    input  logic                  pt_busy,
    output logic                  pt_ren,
    output logic [PADDR_BITS-1:0] pt_addr,
    output walk_rsp_t             rsp
);

    localparam int LEVEL_BITS = (WALK_LEVELS > 1) ? $clog2(WALK_LEVELS) : 1;

    typedef enum logic {IDLE, WALK} walk_state_t;

    walk_state_t              state;
    logic [LEVEL_BITS-1:0]    level;
    logic [PADDR_BITS-1:0]    addr;  // pte address of this level
    logic [VPN_PART_BITS-1:0] vpn0;  // kept for the second read
    pte_t                     pte;
    logic                     pte_bad;
    logic                     pte_leaf;
    logic                     last_level;
    logic                     fault_now;

    assign pte        = pte_t'(pt_rdata);
    assign pte_bad    = !pte.perms.v || (pte.perms.w && !pte.perms.r);  // w without r reserved
    assign pte_leaf   = pte.perms.r || pte.perms.x;
    assign last_level = level == '0;
    // leaf at level 1 would be a superpage
    assign fault_now  = pte_bad || (last_level ? !pte_leaf : pte_leaf);

    assign pt_ren  = state == WALK;
    assign pt_addr = addr;

    always_comb begin
        rsp = '0;
        if (state == WALK && !pt_busy && (fault_now || last_level)) begin
            rsp.done  = 1'b1;
            rsp.fault = fault_now;
            rsp.pte   = fault_now ? '0 : pte;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            level <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= WALK;
                        level <= LEVEL_BITS'(WALK_LEVELS - 1);
                    end
                end
                WALK: begin
                    if (rsp.done) begin
                        state <= IDLE;
                    end else if (!pt_busy) begin
                        level <= level - 1'b1;  // descend to the next table
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && start) begin
            addr <= {root_ppn, va.walk.vpn1, 2'b00};
            vpn0 <= va.walk.vpn0;
        end else if (state == WALK && !pt_busy && !rsp.done) begin
            addr <= {pte.ppn, vpn0, 2'b00};
        end
    end

    // a read held off by the memory keeps its request and address
    a_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        pt_ren && pt_busy |=> pt_ren && $stable(pt_addr));

    // the TLB never restarts a walk that is still running
    a_start_idle: assert property (@(posedge CLK) disable iff (!nRST)
        start |-> state == IDLE);

endmodule

// ==== design/tlb.sv ====
/*
 * two-way set-associative data TLB
 * clears on reset, hits in the request cycle, fills from the walker, fence scan
 */
`timescale 1ns/10ps

module tlb
    import tlb_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  mem_req_t              req,
    input  satp_t                 satp,
    input  logic                  fence,
    input  fence_t                fence_cfg,
    input  walk_rsp_t             walk_rsp,
    output logic                  busy,
    output logic [PADDR_BITS-1:0] paddr,
    output pte_t                  hit_pte,
    output logic                  hit,
    output access_t               access,
    output logic                  walk_start,
    output va_u                   walk_va,
    output logic                  walk_fault,
    output logic                  fence_done
);

    localparam int FRAME_BITS = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1;  // way index
    localparam int SCAN_BITS  = SET_BITS + FRAME_BITS;

    typedef enum logic [1:0] {CLEAR, READY, FILL, FENCE} tlb_state_t;

    tlb_state_t            state, next_state;
    logic [SCAN_BITS-1:0]  scan_cnt;                // set then way
    logic [FRAME_BITS-1:0] last_used [TLB_SETS];    // nru way per set
    logic [FRAME_BITS-1:0] hit_way;
    logic [FRAME_BITS-1:0] ridx;
    logic [FRAME_BITS-1:0] scan_way;
    logic [SET_BITS-1:0]   scan_set;
    logic [SET_BITS-1:0]   sel;
    va_u                   req_va;
    va_u                   fence_va;
    tlb_set_t              rd_set;
    tlb_set_t              wr_set;
    tlb_set_t              wr_mask;
    tlb_frame_t            scan_frame;
    logic                  sram_wen;
    logic                  req_active;
    logic                  way_hit;
    logic                  fence_match;
    logic                  scan_last;

    assign req_va     = req.addr;
    assign fence_va   = fence_cfg.va;
    assign walk_va    = req_va;
    assign req_active = req.ren || req.wen;
    assign access     = req.wen ? ACCESS_STORE : (req.ren ? ACCESS_LOAD : ACCESS_NONE);

    assign scan_set  = scan_cnt[FRAME_BITS +: SET_BITS];
    assign scan_way  = scan_cnt[FRAME_BITS-1:0];
    assign scan_last = scan_cnt == SCAN_BITS'(TLB_SETS * TLB_WAYS - 1);

    always_comb begin
        case (state)
            CLEAR:   sel = scan_cnt[SET_BITS-1:0];  // one set per cycle
            FENCE:   sel = scan_set;
            default: sel = req_va.tlb.set;
        endcase
    end

    tlb_sram #(.WIDTH($bits(tlb_set_t)), .DEPTH(TLB_SETS)) sram0 (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sel),
        .wen   (sram_wen),
        .wdata (wr_set),
        .wmask (wr_mask),
        .rdata (rd_set)
    );

    // tag compare across both ways
    always_comb begin
        way_hit = 1'b0;
        hit_way = '0;
        for (int i = 0; i < TLB_WAYS; i++) begin
            if (rd_set.frames[i].tag.valid && rd_set.frames[i].tag.tag == req_va.tlb.tag &&
                rd_set.frames[i].tag.asid == satp.asid) begin
                way_hit = 1'b1;
                hit_way = FRAME_BITS'(i);
            end
        end
    end

    assign hit     = state == READY && satp.trans_on && req_active && way_hit && !fence;
    assign hit_pte = hit ? rd_set.frames[hit_way].pte : '0;
    assign paddr   = satp.trans_on ? {hit_pte.ppn, req_va.tlb.offset} : PADDR_BITS'(req.addr);

    // victim is the way after the last used one
    always_comb begin
        ridx = last_used[req_va.tlb.set] + 1'b1;
        if (last_used[req_va.tlb.set] == FRAME_BITS'(TLB_WAYS - 1)) begin
            ridx = '0;
        end
    end

    assign scan_frame  = rd_set.frames[scan_way];
    assign fence_match = scan_frame.tag.valid &&
        (fence_cfg.va == '0 ||
         (scan_frame.tag.tag == fence_va.tlb.tag && scan_set == fence_va.tlb.set)) &&
        (fence_cfg.asid == '0 ||
         (scan_frame.tag.asid == fence_cfg.asid && !scan_frame.pte.perms.g));

    always_comb begin
        next_state = state;
        busy       = 1'b1;
        walk_start = 1'b0;
        walk_fault = 1'b0;
        fence_done = 1'b0;
        sram_wen   = 1'b0;
        wr_set     = '0;
        wr_mask    = '1;
        case (state)
            CLEAR: begin
                sram_wen = 1'b1;
                wr_mask  = '0;
                if (scan_cnt[SET_BITS-1:0] == SET_BITS'(TLB_SETS - 1)) begin
                    next_state = READY;
                end
            end
            READY: begin
                if (fence) begin  // fence wins over a miss
                    next_state = FENCE;
                end else if (!satp.trans_on || way_hit) begin
                    busy = 1'b0;
                end else if (req_active) begin
                    walk_start = 1'b1;
                    next_state = FILL;
                end
            end
            FILL: begin
                if (walk_rsp.done) begin
                    next_state = READY;
                    if (walk_rsp.fault) begin
                        walk_fault = 1'b1;  // release the pipeline with the fault
                        busy       = 1'b0;
                    end else begin
                        sram_wen                     = 1'b1;
                        wr_set.frames[ridx].tag.valid = 1'b1;
                        wr_set.frames[ridx].tag.asid  = satp.asid;
                        wr_set.frames[ridx].tag.tag   = req_va.tlb.tag;
                        wr_set.frames[ridx].pte       = walk_rsp.pte;
                        wr_mask.frames[ridx]          = '0;
                    end
                end
            end
            FENCE: begin
                if (fence_match) begin
                    sram_wen                 = 1'b1;
                    wr_mask.frames[scan_way] = '0;
                end
                if (scan_last) begin
                    fence_done = 1'b1;
                    next_state = READY;
                end
            end
            default: next_state = CLEAR;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= CLEAR;
            scan_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == CLEAR || state == FENCE) begin
                scan_cnt <= scan_cnt + 1'b1;
            end else begin
                scan_cnt <= '0;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < TLB_SETS; i++) begin
                last_used[i] <= '0;
            end
        end else if (hit) begin
            last_used[req_va.tlb.set] <= hit_way;
        end
    end

    // reset clearing runs once, nothing goes back to CLEAR
    a_clear_once: assert property (@(posedge CLK) disable iff (!nRST)
        state != CLEAR |=> state != CLEAR);

    // the walker only answers while a fill is waiting
    a_walk_rsp_fill: assert property (@(posedge CLK) disable iff (!nRST)
        walk_rsp.done |-> state == FILL);

endmodule

// ==== design/tlb_pkg.sv ====
/*
 * shared Sv32 translation types and sizes for the data TLB,
 * the page table walker and the permission checker
 */
package tlb_pkg;

    localparam int PAGE_OFFSET_BITS = 12;  // 4 KiB pages
    localparam int VPN_BITS         = 20;
    localparam int VPN_PART_BITS    = 10;  // one walk level index
    localparam int PPN_BITS         = 22;
    localparam int PADDR_BITS       = 34;
    localparam int ASID_BITS        = 9;
    localparam int TLB_WAYS         = 2;
    localparam int TLB_SETS         = 16;
    localparam int SET_BITS         = 4;
    localparam int TAG_BITS         = VPN_BITS - SET_BITS;
    localparam int WALK_LEVELS      = 2;

    // privilege mode encodings
    localparam logic [1:0] PRV_U = 2'b00;
    localparam logic [1:0] PRV_S = 2'b01;
    localparam logic [1:0] PRV_M = 2'b11;

    typedef struct packed {
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_perms_t;

    typedef struct packed {
        logic [PPN_BITS-1:0] ppn;
        pte_perms_t          perms;
    } pte_t;

    // same 32-bit VA, split for set lookup or for the two walk levels
    typedef struct packed {
        logic [TAG_BITS-1:0]         tag;
        logic [SET_BITS-1:0]         set;
        logic [PAGE_OFFSET_BITS-1:0] offset;
    } va_tlb_t;

    typedef struct packed {
        logic [VPN_PART_BITS-1:0]    vpn1;
        logic [VPN_PART_BITS-1:0]    vpn0;
        logic [PAGE_OFFSET_BITS-1:0] offset;
    } va_walk_t;

    typedef union packed {
        va_tlb_t  tlb;
        va_walk_t walk;
    } va_u;

    typedef struct packed {
        logic                 valid;
        logic [ASID_BITS-1:0] asid;
        logic [TAG_BITS-1:0]  tag;
    } tlb_tag_t;

    typedef struct packed {
        tlb_tag_t tag;
        pte_t     pte;
    } tlb_frame_t;  // 58 bits

    typedef struct packed {
        tlb_frame_t [TLB_WAYS-1:0] frames;
    } tlb_set_t;

    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                 trans_on;
        logic [ASID_BITS-1:0] asid;
        logic [PPN_BITS-1:0]  ppn;  // root table
    } satp_t;

    typedef struct packed {
        logic [1:0] mode;
        logic       sum;
        logic       mxr;
    } prv_t;

    typedef struct packed {
        logic [31:0]          va;    // zero fences every page
        logic [ASID_BITS-1:0] asid;  // zero fences every space
    } fence_t;

    typedef enum logic [1:0] {
        ACCESS_NONE,
        ACCESS_LOAD,
        ACCESS_STORE
    } access_t;

    typedef struct packed {
        logic done;
        logic fault;
        pte_t pte;
    } walk_rsp_t;

endpackage

// ==== design/tlb_sram.sv ====
/*
 * tlb set array
 * combinational read, synchronous write of the bits with a zero mask bit
 */
`timescale 1ns/10ps

module tlb_sram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [$clog2(DEPTH)-1:0] sel,
    input  logic                     wen,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [WIDTH-1:0]         wmask,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    assign rdata = mem[sel];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            // mask bit set keeps the old bit
            mem[sel] <= (mem[sel] & wmask) | (wdata & ~wmask);
        end
    end

endmodule

// ==== filelist.f ====
design/tlb_pkg.sv
design/tlb_sram.sv
design/page_perm_check.sv
design/tlb.sv
design/page_walker.sv
design/mmu_top.sv
test/pt_memory.sv
test/tb_mmu.sv

// ==== test/pt_memory.sv ====
/*
 * page table memory model for the walker port
 * word addressed, fixed read latency, counts the reads it serves
 */
`timescale 1ns/10ps

module pt_memory #(
    parameter int LATENCY = 3,
    parameter int WORDS   = 4096
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        ren,
    input  logic [33:0] addr,
    output logic [31:0] rdata,
    output logic        busy
);

    logic [31:0]              words [WORDS];
    logic [$clog2(WORDS)-1:0] index;
    int                       wait_cnt;
    int                       reads;  // served reads since reset

    assign index = addr[$clog2(WORDS)+1:2];
    assign busy  = ren && wait_cnt < LATENCY;
    assign rdata = (ren && !busy) ? words[index] : '0;  // only valid in the served cycle

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 0;
            reads    <= 0;
        end else if (ren && !busy) begin
            wait_cnt <= 0;  // ready for the next read
            reads    <= reads + 1;
        end else if (ren) begin
            wait_cnt <= wait_cnt + 1;
        end else begin
            wait_cnt <= 0;
        end
    end

endmodule

// ==== test/tb_mmu.sv ====
/*
 * directed testbench for the data MMU
 * builds Sv32 tables in the memory model and checks translation, faults and fences
 */
`timescale 1ns/10ps

module tb_mmu
    import tlb_pkg::*;
();

    localparam int          CLK_PERIOD = 10;
    localparam int          NUM_TESTS  = 6;
    localparam int          WAIT_LIMIT = 200;  // cycles per access or fence
    localparam logic [21:0] ROOT_PPN   = 22'd1;
    localparam logic [21:0] L0_PPN     = 22'd2;
    localparam logic [9:0]  VPN1       = 10'd1;  // every test page lives under this entry

    // pte low bits
    localparam logic [9:0] PERM_V  = 10'h001;
    localparam logic [9:0] PERM_R  = 10'h002;
    localparam logic [9:0] PERM_W  = 10'h004;
    localparam logic [9:0] PERM_U  = 10'h010;
    localparam logic [9:0] PERM_G  = 10'h020;
    localparam logic [9:0] PERM_A  = 10'h040;
    localparam logic [9:0] PERM_D  = 10'h080;
    localparam logic [9:0] LEAF_RW = PERM_V | PERM_R | PERM_W | PERM_A | PERM_D;

    logic        CLK;
    logic        nRST;
    mem_req_t    req;
    satp_t       satp;
    prv_t        prv;
    logic        fence;
    fence_t      fence_cfg;
    logic [31:0] pt_rdata;
    logic        pt_busy;
    logic        busy;
    logic [33:0] paddr;
    logic        fault_load;
    logic        fault_store;
    logic        fence_done;
    logic        pt_ren;
    logic [33:0] pt_addr;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    logic [33:0] served_addrs [$];  // table addresses read during one access

    mmu_top dut0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .req         (req),
        .satp        (satp),
        .prv         (prv),
        .fence       (fence),
        .fence_cfg   (fence_cfg),
        .pt_rdata    (pt_rdata),
        .pt_busy     (pt_busy),
        .busy        (busy),
        .paddr       (paddr),
        .fault_load  (fault_load),
        .fault_store (fault_store),
        .fence_done  (fence_done),
        .pt_ren      (pt_ren),
        .pt_addr     (pt_addr)
    );

    pt_memory #(.LATENCY(3), .WORDS(4096)) pt_mem0 (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (pt_ren),
        .addr  (pt_addr),
        .rdata (pt_rdata),
        .busy  (pt_busy)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // address of each read in the cycle the memory serves it
    always @(negedge CLK) begin
        if (pt_ren && !pt_busy) begin
            served_addrs.push_back(pt_addr);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // memory covers ppn 0 to 3
    function automatic logic [11:0] pte_index(logic [21:0] table_ppn, logic [9:0] vpn);
        return {table_ppn[1:0], vpn};
    endfunction

    function automatic logic [31:0] page_va(logic [9:0] vpn0, logic [11:0] offset);
        return {VPN1, vpn0, offset};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic map_page(input logic [9:0] vpn0, input logic [21:0] ppn,
                            input logic [9:0] perms);
        pt_mem0.words[pte_index(ROOT_PPN, VPN1)] = {L0_PPN, PERM_V};  // pointer to level 0
        pt_mem0.words[pte_index(L0_PPN, vpn0)]   = {ppn, perms};
    endtask

    // root entry first, then the level 0 entry of the test tables
    task automatic check_walk_addrs(input string name, input logic [31:0] va);
        logic [33:0] root_addr;
        logic [33:0] leaf_addr;
        root_addr = 34'(ROOT_PPN) * 34'd4096 + 34'(va[31:22]) * 34'd4;
        leaf_addr = 34'(L0_PPN) * 34'd4096 + 34'(va[21:12]) * 34'd4;
        if (served_addrs.size() == 2) begin
            check_value({name, " root pte addr"}, 64'(root_addr), 64'(served_addrs[0]));
            check_value({name, " leaf pte addr"}, 64'(leaf_addr), 64'(served_addrs[1]));
        end
    endtask

    // drives one request and waits for busy to fall, checks faults and table reads
    task automatic access_check(input string name, input logic [31:0] va, input logic store,
                                input int exp_reads, input logic exp_fault,
                                output logic [33:0] pa, output int cycles);
        int   reads_before;
        logic fl;
        logic fs;
        reads_before = pt_mem0.reads;
        served_addrs.delete();
        req.addr     = va;
        req.ren      = !store;
        req.wen      = store;
        cycles       = 0;
        @(negedge CLK);
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (busy) begin
            $display("%s: busy stayed high, the request never completed", name);
            errors++;
        end
        pa = paddr;
        fl = fault_load;
        fs = fault_store;
        @(posedge CLK);
        #1;
        req = '0;
        check_value({name, " load fault"}, 64'(!store && exp_fault), 64'(fl));
        check_value({name, " store fault"}, 64'(store && exp_fault), 64'(fs));
        check_value({name, " reads"}, 64'(exp_reads), 64'(pt_mem0.reads - reads_before));
        if (exp_reads == 2) begin
            check_walk_addrs(name, va);
        end
    endtask

    task automatic fence_check(input string name, input logic [31:0] va,
                               input logic [8:0] asid);
        int cycles;
        fence_cfg.va   = va;
        fence_cfg.asid = asid;
        fence          = 1'b1;
        cycles         = 0;
        @(negedge CLK);
        do begin
            @(posedge CLK);
            #1;
            fence = 1'b0;  // single cycle strobe
            cycles++;
            @(negedge CLK);
        end while (!fence_done && cycles < WAIT_LIMIT);
        if (!fence_done) begin
            $display("%s: fence_done never pulsed after the fence", name);
            errors++;
        end else begin
            check_value({name, " done cycles"}, 64'(TLB_SETS * TLB_WAYS), 64'(cycles));
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (busy) begin
            $display("reset: the TLB never left its clearing state");
            errors++;
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic test_trans_off();
        logic [31:0] va;
        logic [33:0] pa;
        int          cycles;
        va = lcg_next();
        satp.trans_on = 1'b0;
        access_check("trans_off", va, 1'b0, 0, 1'b0, pa, cycles);
        check_value("trans_off paddr", 64'({2'b00, va}), 64'(pa));
        check_value("trans_off cycles", 64'(0), 64'(cycles));
    endtask

    task automatic test_miss_hit();
        logic [31:0] r;
        logic [21:0] ppn;
        logic [11:0] off;
        logic [33:0] pa;
        int          cycles;
        satp.trans_on = 1'b1;
        satp.asid     = 9'd1;
        satp.ppn      = ROOT_PPN;
        r   = lcg_next();
        ppn = r[31:10];
        map_page(10'h010, ppn, LEAF_RW);
        r   = lcg_next();
        off = r[27:16];
        access_check("miss_hit first", page_va(10'h010, off), 1'b0, 2, 1'b0, pa, cycles);
        check_value("miss_hit first paddr", 64'({ppn, off}), 64'(pa));
        r   = lcg_next();
        off = r[27:16];
        access_check("miss_hit repeat", page_va(10'h010, off), 1'b1, 0, 1'b0, pa, cycles);
        check_value("miss_hit repeat paddr", 64'({ppn, off}), 64'(pa));
        check_value("miss_hit repeat cycles", 64'(0), 64'(cycles));
    endtask

    task automatic test_permissions();
        logic [31:0] r;
        logic [21:0] ppn_ro;
        logic [21:0] ppn_u;
        logic [33:0] pa;
        int          cycles;
        r      = lcg_next();
        ppn_ro = r[31:10];
        r      = lcg_next();
        ppn_u  = r[31:10];
        map_page(10'h021, ppn_ro, PERM_V | PERM_R | PERM_A);
        map_page(10'h022, ppn_u, LEAF_RW | PERM_U);
        access_check("perm ro store", page_va(10'h021, 12'h0), 1'b1, 2, 1'b1, pa, cycles);
        access_check("perm ro load", page_va(10'h021, 12'h4), 1'b0, 0, 1'b0, pa, cycles);
        check_value("perm ro load paddr", 64'({ppn_ro, 12'h4}), 64'(pa));
        prv.sum = 1'b0;
        access_check("perm user no sum", page_va(10'h022, 12'h8), 1'b0, 2, 1'b1, pa, cycles);
        prv.sum = 1'b1;  // supervisor may now read user pages
        access_check("perm user sum", page_va(10'h022, 12'h8), 1'b0, 0, 1'b0, pa, cycles);
        check_value("perm user sum paddr", 64'({ppn_u, 12'h8}), 64'(pa));
        prv.sum = 1'b0;
    endtask

    task automatic test_walk_fault();
        logic [33:0] pa;
        int          cycles;
        pt_mem0.words[pte_index(ROOT_PPN, VPN1)] = {L0_PPN, PERM_V};
        pt_mem0.words[pte_index(L0_PPN, 10'h033)] = '0;  // invalid leaf
        access_check("walk fault store", page_va(10'h033, 12'h0), 1'b1, 2, 1'b1, pa, cycles);
        access_check("walk fault retry", page_va(10'h033, 12'h0), 1'b0, 2, 1'b1, pa, cycles);
    endtask

    task automatic test_asid_fence();
        logic [31:0] r;
        logic [21:0] ppn_p;
        logic [21:0] ppn_q;
        logic [21:0] ppn_g;
        logic [33:0] pa;
        int          cycles;
        r     = lcg_next();
        ppn_p = r[31:10];
        r     = lcg_next();
        ppn_q = r[31:10];
        r     = lcg_next();
        ppn_g = r[31:10];
        map_page(10'h044, ppn_p, LEAF_RW);
        map_page(10'h045, ppn_q, LEAF_RW);
        map_page(10'h046, ppn_g, LEAF_RW | PERM_G);
        satp.asid = 9'd1;
        access_check("asid p first", page_va(10'h044, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        check_value("asid p paddr", 64'({ppn_p, 12'h0}), 64'(pa));
        access_check("asid p again", page_va(10'h044, 12'h0), 1'b0, 0, 1'b0, pa, cycles);
        access_check("asid q first", page_va(10'h045, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        access_check("asid g first", page_va(10'h046, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        satp.asid = 9'd2;
        access_check("asid p other space", page_va(10'h044, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        check_value("asid p other paddr", 64'({ppn_p, 12'h0}), 64'(pa));
        satp.asid = 9'd1;
        fence_check("fence by va", page_va(10'h044, 12'h0), 9'd0);
        access_check("va fence q kept", page_va(10'h045, 12'h0), 1'b0, 0, 1'b0, pa, cycles);
        access_check("va fence g kept", page_va(10'h046, 12'h0), 1'b0, 0, 1'b0, pa, cycles);
        access_check("va fence p refill", page_va(10'h044, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        fence_check("fence by asid", 32'd0, 9'd1);
        access_check("asid fence g kept", page_va(10'h046, 12'h0), 1'b0, 0, 1'b0, pa, cycles);
        check_value("asid fence g paddr", 64'({ppn_g, 12'h0}), 64'(pa));
        access_check("asid fence q refill", page_va(10'h045, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
    endtask

    // three pages of set 7
    task automatic test_replacement();
        logic [31:0] r;
        logic [33:0] pa;
        int          cycles;
        r = lcg_next();
        map_page(10'h057, r[31:10], LEAF_RW);
        r = lcg_next();
        map_page(10'h067, r[31:10], LEAF_RW);
        r = lcg_next();
        map_page(10'h077, r[31:10], LEAF_RW);
        access_check("nru a fill", page_va(10'h057, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        access_check("nru b fill", page_va(10'h067, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        access_check("nru a touch", page_va(10'h057, 12'h0), 1'b0, 0, 1'b0, pa, cycles);
        access_check("nru c fill", page_va(10'h077, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
        access_check("nru a kept", page_va(10'h057, 12'h0), 1'b0, 0, 1'b0, pa, cycles);
        access_check("nru b evicted", page_va(10'h067, 12'h0), 1'b0, 2, 1'b0, pa, cycles);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        lcg_state = 32'hbd2d;
        nRST      = 1'b0;
        req       = '0;
        satp      = '0;
        prv       = '0;
        prv.mode  = PRV_S;
        fence     = 1'b0;
        fence_cfg = '0;
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;
        @(negedge CLK);
        check_value("reset busy", 64'(1), 64'(busy));
        check_value("reset pt_ren", 64'(0), 64'(pt_ren));
        check_value("reset fence_done", 64'(0), 64'(fence_done));
        check_value("reset faults", 64'(0), 64'({fault_load, fault_store}));
        @(posedge CLK);
        #1;
        wait_ready();
        test_trans_off();
        test_miss_hit();
        test_permissions();
        test_walk_fault();
        test_asid_fence();
        test_replacement();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, a bounded number of cycles per test
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("watchdog: the tests did not finish in time, errors so far: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule
